// ==== filelist.f ====
+incdir+include
source/x86_pipe_pkg.sv
source/decode_stage.sv
source/register_file.sv
source/execute_stage.sv
source/writeback_stage.sv
source/x86_pipe_top.sv
verif/x86_pipe_tb.sv

// ==== include/x86_pipe_consts.svh ====
`ifndef X86_PIPE_CONSTS_SVH
`define X86_PIPE_CONSTS_SVH

// Datapath and register file sizes
`define XLEN_W        32
`define REG_COUNT     8
`define REG_IDX_W     3
`define IMM_W         16
`define STORE_ADDR_W  16

// Instruction word fields
`define OPC_MSB       31
`define OPC_LSB       28
`define DST_MSB       27
`define DST_LSB       25
`define SRC_MSB       24
`define SRC_LSB       22
`define IMM_MSB       15

`endif

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "x86_pipe_consts.svh"

module decode_stage (
   input  wire                         clk,
   input  wire                         rst_n,
   input  wire                         instr_valid,
   output logic                        instr_ready,
   input  wire  x86_pipe_pkg::word_t    instr_word,
   output logic                        issue_valid,
   input  wire                         issue_ready,
   output x86_pipe_pkg::opcode_e       issue_opcode,
   output x86_pipe_pkg::reg_idx_t      issue_dst,
   output x86_pipe_pkg::word_t         issue_a,
   output x86_pipe_pkg::word_t         issue_b,
   output x86_pipe_pkg::reg_idx_t      rd_idx_a,
   output x86_pipe_pkg::reg_idx_t      rd_idx_b,
   input  wire  x86_pipe_pkg::word_t    rd_data_a,
   input  wire  x86_pipe_pkg::word_t    rd_data_b,
   input  wire                         retire_en,
   input  wire  x86_pipe_pkg::reg_idx_t retire_idx
);
   import x86_pipe_pkg::*;

   logic                  full;
   word_t                 instr_q;
   logic [`REG_COUNT-1:0] scoreboard;   // Writes in flight per register
   logic [`REG_COUNT-1:0] sb_set;
   logic [`REG_COUNT-1:0] sb_clr;
   logic [3:0]            opc_field;
   reg_idx_t              dst_idx;
   reg_idx_t              src_idx;
   logic [`IMM_W-1:0]     imm;
   logic                  check_dst;
   logic                  reads_src;
   logic                  hazard;
   logic                  issue_fire;

   assign opc_field = instr_q[`OPC_MSB:`OPC_LSB];
   assign dst_idx   = instr_q[`DST_MSB:`DST_LSB];
   assign src_idx   = instr_q[`SRC_MSB:`SRC_LSB];
   assign imm       = instr_q[`IMM_MSB:0];

   always_comb begin
      if (opc_field > op_store)
         issue_opcode = op_nop;   // Undefined codes
      else
         issue_opcode = opcode_e'(opc_field);
   end

   // Dst is read or written by everything but nop, so it also guards WAW
   assign check_dst = (issue_opcode != op_nop);
   assign reads_src = (issue_opcode inside {op_add, op_sub, op_and, op_or, op_xor});
   assign hazard    = (check_dst & scoreboard[dst_idx]) | (reads_src & scoreboard[src_idx]);

   assign issue_valid = full & ~hazard;
   assign issue_fire  = issue_valid & issue_ready;
   assign instr_ready = ~full | issue_fire;

   assign rd_idx_a  = dst_idx;
   assign rd_idx_b  = src_idx;
   assign issue_dst = dst_idx;
   assign issue_a   = rd_data_a;
   assign issue_b   = (issue_opcode inside {op_addi, op_movi, op_store}) ?
                      {{(`XLEN_W-`IMM_W){1'b0}}, imm} : rd_data_b;

   always_comb begin
      sb_set = '0;
      sb_clr = '0;
      if (issue_fire && op_writes_reg(issue_opcode))
         sb_set[dst_idx] = 1'b1;
      if (retire_en)
         sb_clr[retire_idx] = 1'b1;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         full       <= 1'b0;
         scoreboard <= '0;
      end else begin
         if (instr_valid && instr_ready)
            full <= 1'b1;
         else if (issue_fire)
            full <= 1'b0;
         scoreboard <= (scoreboard & ~sb_clr) | sb_set;
      end
   end

   always_ff @(posedge clk) begin
      if (instr_valid && instr_ready)
         instr_q <= instr_word;
   end

   // Retire from writeback must match a bit set at issue
   a_retire_pending : assert property (@(posedge clk) disable iff (!rst_n)
      retire_en |-> scoreboard[retire_idx]);

endmodule

`default_nettype wire

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "x86_pipe_consts.svh"

module execute_stage (
   input  wire                            clk,
   input  wire                            rst_n,
   input  wire                            issue_valid,
   output logic                           issue_ready,
   input  wire  x86_pipe_pkg::opcode_e     issue_opcode,
   input  wire  x86_pipe_pkg::reg_idx_t    issue_dst,
   input  wire  x86_pipe_pkg::word_t       issue_a,
   input  wire  x86_pipe_pkg::word_t       issue_b,
   output logic                           res_valid,
   input  wire                            res_ready,
   output x86_pipe_pkg::opcode_e          res_opcode,
   output x86_pipe_pkg::reg_idx_t         res_dst,
   output x86_pipe_pkg::word_t            res_data,
   output x86_pipe_pkg::store_addr_t      res_addr
);
   import x86_pipe_pkg::*;

   logic  fire;
   word_t alu_out;

   // One entry that refills in the same cycle it drains
   assign issue_ready = ~res_valid | res_ready;
   assign fire        = issue_valid & issue_ready;

   always_comb begin
      case (issue_opcode)
         op_add,
         op_addi:  alu_out = issue_a + issue_b;   // Wraps at 32 bits
         op_sub:   alu_out = issue_a - issue_b;
         op_and:   alu_out = issue_a & issue_b;
         op_or:    alu_out = issue_a | issue_b;
         op_xor:   alu_out = issue_a ^ issue_b;
         op_movi:  alu_out = issue_b;
         op_store: alu_out = issue_a;             // Store data
         default:  alu_out = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         res_valid <= 1'b0;
      end else if (fire) begin
         res_valid <= 1'b1;
      end else if (res_ready) begin
         res_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (fire) begin
         res_opcode <= issue_opcode;
         res_dst    <= issue_dst;
         res_data   <= alu_out;
         res_addr   <= issue_b[`STORE_ADDR_W-1:0];
      end
   end

   a_res_hold : assert property (@(posedge clk) disable iff (!rst_n)
      res_valid && !res_ready |=> res_valid && $stable(res_opcode) &&
      $stable(res_dst) && $stable(res_data) && $stable(res_addr));

endmodule

`default_nettype wire

// ==== source/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "x86_pipe_consts.svh"

module register_file (
   input  wire                         clk,
   input  wire                         rst_n,
   input  wire  x86_pipe_pkg::reg_idx_t rd_idx_a,
   input  wire  x86_pipe_pkg::reg_idx_t rd_idx_b,
   output x86_pipe_pkg::word_t         rd_data_a,
   output x86_pipe_pkg::word_t         rd_data_b,
   input  wire                         wr_en,
   input  wire  x86_pipe_pkg::reg_idx_t wr_idx,
   input  wire  x86_pipe_pkg::word_t    wr_data
);
   import x86_pipe_pkg::*;

   word_t regs [`REG_COUNT];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_idx] <= wr_data;
      end
   end

   // Async reads see a write the cycle after wr_en
   assign rd_data_a = regs[rd_idx_a];
   assign rd_data_b = regs[rd_idx_b];

endmodule

`default_nettype wire

// ==== source/writeback_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
   input  wire                            clk,
   input  wire                            rst_n,
   input  wire                            res_valid,
   output logic                           res_ready,
   input  wire  x86_pipe_pkg::opcode_e     res_opcode,
   input  wire  x86_pipe_pkg::reg_idx_t    res_dst,
   input  wire  x86_pipe_pkg::word_t       res_data,
   input  wire  x86_pipe_pkg::store_addr_t res_addr,
   output logic                           wr_en,
   output x86_pipe_pkg::reg_idx_t         wr_idx,
   output x86_pipe_pkg::word_t            wr_data,
   output logic                           retire_en,
   output x86_pipe_pkg::reg_idx_t         retire_idx,
   output logic                           wmem_valid,
   input  wire                            wmem_ready,
   output x86_pipe_pkg::store_addr_t      wmem_address,
   output x86_pipe_pkg::word_t            wmem_data,
   output logic                           commit_valid,
   output x86_pipe_pkg::opcode_e          commit_opcode,
   output x86_pipe_pkg::reg_idx_t         commit_reg,
   output x86_pipe_pkg::word_t            commit_data
);
   import x86_pipe_pkg::*;

   logic     res_fire;
   logic     mem_fire;
   logic     is_store;
   reg_idx_t store_reg;

   // Pending store blocks new results, so two commits never collide
   assign res_ready = ~wmem_valid;
   assign res_fire  = res_valid & res_ready;
   assign mem_fire  = wmem_valid & wmem_ready;
   assign is_store  = (res_opcode == op_store);

   // Scoreboard clears on the same edge the register file is written
   assign retire_en  = wr_en;
   assign retire_idx = wr_idx;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_en        <= 1'b0;
         commit_valid <= 1'b0;
         wmem_valid   <= 1'b0;
      end else begin
         wr_en        <= res_fire & op_writes_reg(res_opcode);
         commit_valid <= (res_fire & ~is_store) | mem_fire;
         if (res_fire && is_store)
            wmem_valid <= 1'b1;
         else if (mem_fire)
            wmem_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (res_fire) begin
         wr_idx  <= res_dst;
         wr_data <= res_data;
      end
      if (res_fire && is_store) begin
         wmem_address <= res_addr;
         wmem_data    <= res_data;
         store_reg    <= res_dst;
      end
      if (mem_fire) begin
         commit_opcode <= op_store;
         commit_reg    <= store_reg;
         commit_data   <= wmem_data;
      end else if (res_fire && !is_store) begin
         commit_opcode <= res_opcode;
         commit_reg    <= res_dst;
         commit_data   <= res_data;   // Zero for nop
      end
   end

   a_wmem_hold : assert property (@(posedge clk) disable iff (!rst_n)
      wmem_valid && !wmem_ready |=>
      wmem_valid && $stable(wmem_address) && $stable(wmem_data));

endmodule

`default_nettype wire

// ==== source/x86_pipe_pkg.sv ====
`default_nettype none

`include "x86_pipe_consts.svh"

package x86_pipe_pkg;

   typedef enum logic [3:0] {
      op_nop   = 4'd0,
      op_add,
      op_sub,
      op_and,
      op_or,
      op_xor,
      op_addi,
      op_movi,
      op_store
   } opcode_e;

   typedef logic [`XLEN_W-1:0]       word_t;
   typedef logic [`REG_IDX_W-1:0]    reg_idx_t;
   typedef logic [`STORE_ADDR_W-1:0] store_addr_t;

   // Ops that update the destination register
   function automatic logic op_writes_reg(opcode_e op);
      return (op != op_nop) && (op != op_store);
   endfunction

endpackage

`default_nettype wire

// ==== source/x86_pipe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module x86_pipe_top (
   input  wire                            clk,
   input  wire                            rst_n,
   input  wire                            instr_valid,
   output logic                           instr_ready,
   input  wire  x86_pipe_pkg::word_t       instr_word,
   output logic                           wmem_valid,
   input  wire                            wmem_ready,
   output x86_pipe_pkg::store_addr_t      wmem_address,
   output x86_pipe_pkg::word_t            wmem_data,
   output logic                           commit_valid,
   output x86_pipe_pkg::opcode_e          commit_opcode,
   output x86_pipe_pkg::reg_idx_t         commit_reg,
   output x86_pipe_pkg::word_t            commit_data
);
   import x86_pipe_pkg::*;

   // Issue handshake
   logic        issue_valid;
   logic        issue_ready;
   opcode_e     issue_opcode;
   reg_idx_t    issue_dst;
   word_t       issue_a;
   word_t       issue_b;

   // Result handshake
   logic        res_valid;
   logic        res_ready;
   opcode_e     res_opcode;
   reg_idx_t    res_dst;
   word_t       res_data;
   store_addr_t res_addr;

   // Register file ports and scoreboard retire
   reg_idx_t    rd_idx_a;
   reg_idx_t    rd_idx_b;
   word_t       rd_data_a;
   word_t       rd_data_b;
   logic        wr_en;
   reg_idx_t    wr_idx;
   word_t       wr_data;
   logic        retire_en;
   reg_idx_t    retire_idx;

   decode_stage i_decode (
      .clk          (clk),
      .rst_n        (rst_n),
      .instr_valid  (instr_valid),
      .instr_ready  (instr_ready),
      .instr_word   (instr_word),
      .issue_valid  (issue_valid),
      .issue_ready  (issue_ready),
      .issue_opcode (issue_opcode),
      .issue_dst    (issue_dst),
      .issue_a      (issue_a),
      .issue_b      (issue_b),
      .rd_idx_a     (rd_idx_a),
      .rd_idx_b     (rd_idx_b),
      .rd_data_a    (rd_data_a),
      .rd_data_b    (rd_data_b),
      .retire_en    (retire_en),
      .retire_idx   (retire_idx)
   );

   register_file i_regs (
      .clk       (clk),
      .rst_n     (rst_n),
      .rd_idx_a  (rd_idx_a),
      .rd_idx_b  (rd_idx_b),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b),
      .wr_en     (wr_en),
      .wr_idx    (wr_idx),
      .wr_data   (wr_data)
   );

   execute_stage i_execute (
      .clk          (clk),
      .rst_n        (rst_n),
      .issue_valid  (issue_valid),
      .issue_ready  (issue_ready),
      .issue_opcode (issue_opcode),
      .issue_dst    (issue_dst),
      .issue_a      (issue_a),
      .issue_b      (issue_b),
      .res_valid    (res_valid),
      .res_ready    (res_ready),
      .res_opcode   (res_opcode),
      .res_dst      (res_dst),
      .res_data     (res_data),
      .res_addr     (res_addr)
   );

   writeback_stage i_writeback (
      .clk           (clk),
      .rst_n         (rst_n),
      .res_valid     (res_valid),
      .res_ready     (res_ready),
      .res_opcode    (res_opcode),
      .res_dst       (res_dst),
      .res_data      (res_data),
      .res_addr      (res_addr),
      .wr_en         (wr_en),
      .wr_idx        (wr_idx),
      .wr_data       (wr_data),
      .retire_en     (retire_en),
      .retire_idx    (retire_idx),
      .wmem_valid    (wmem_valid),
      .wmem_ready    (wmem_ready),
      .wmem_address  (wmem_address),
      .wmem_data     (wmem_data),
      .commit_valid  (commit_valid),
      .commit_opcode (commit_opcode),
      .commit_reg    (commit_reg),
      .commit_data   (commit_data)
   );

endmodule

`default_nettype wire

// ==== verif/x86_pipe_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "x86_pipe_consts.svh"

module x86_pipe_tb;
   import x86_pipe_pkg::*;

   localparam int NUM_RANDOM     = 192;
   localparam int NUM_INSTR      = `REG_COUNT + NUM_RANDOM;
   localparam int RESET_CYCLES   = 16;
   localparam int TIMEOUT_CYCLES = NUM_INSTR * 40 + RESET_CYCLES;

   logic        clk;
   logic        rst_n;
   logic        instr_valid;
   logic        instr_ready;
   word_t       instr_word;
   logic        wmem_valid;
   logic        wmem_ready;
   store_addr_t wmem_address;
   word_t       wmem_data;
   logic        commit_valid;
   opcode_e     commit_opcode;
   reg_idx_t    commit_reg;
   word_t       commit_data;

   integer seed;
   int     cycle_cnt = 0;
   int     stores_sent;

   // Reference model state
   word_t             fifo_mem [0:255];   // Accepted words with the oldest at rd_ptr
   int                wr_ptr;
   int                rd_ptr;
   int                mem_cnt;
   word_t             model_regs [`REG_COUNT];
   word_t             head_word;
   logic [3:0]        head_op;
   reg_idx_t          head_dst;
   reg_idx_t          head_src;
   logic [`IMM_W-1:0] head_imm;
   word_t             exp_data;

   x86_pipe_top i_dut (
      .clk           (clk),
      .rst_n         (rst_n),
      .instr_valid   (instr_valid),
      .instr_ready   (instr_ready),
      .instr_word    (instr_word),
      .wmem_valid    (wmem_valid),
      .wmem_ready    (wmem_ready),
      .wmem_address  (wmem_address),
      .wmem_data     (wmem_data),
      .commit_valid  (commit_valid),
      .commit_opcode (commit_opcode),
      .commit_reg    (commit_reg),
      .commit_data   (commit_data)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("TESTS FAILED");
      $fatal(1);
   endtask

   function automatic word_t model_result(input logic [3:0] op, input word_t dv,
                                          input word_t sv, input logic [`IMM_W-1:0] imm);
      word_t ext;
      ext = {{(`XLEN_W-`IMM_W){1'b0}}, imm};
      case (op)
         op_add:   return dv + sv;
         op_sub:   return dv - sv;
         op_and:   return dv & sv;
         op_or:    return dv | sv;
         op_xor:   return dv ^ sv;
         op_addi:  return dv + ext;
         op_movi:  return ext;
         op_store: return dv;   // Value sent to memory
         default:  return '0;
      endcase
   endfunction

   function automatic word_t random_instr();
      int    pick;
      word_t w;
      pick = ($random(seed) & 32'h7fff_ffff) % 10;
      w    = $random(seed);
      w[`OPC_MSB:`OPC_LSB] = (pick == 9) ? 4'hf : 4'(pick);   // 4'hf is undefined
      return w;
   endfunction

   task automatic send_instr(input word_t w);
      logic taken;
      while (($random(seed) & 3) == 0) begin
         instr_valid = 1'b0;
         @(posedge clk);
         #1;
      end
      instr_valid = 1'b1;
      instr_word  = w;
      if (w[`OPC_MSB:`OPC_LSB] == op_store)
         stores_sent++;
      taken = 1'b0;
      while (!taken) begin
         @(negedge clk);
         taken = instr_ready;
         @(posedge clk);
         #1;
      end
      instr_valid = 1'b0;
   endtask

   // Oldest outstanding instruction and its expected result
   assign head_word = fifo_mem[rd_ptr];
   assign head_op   = (head_word[`OPC_MSB:`OPC_LSB] > 4'd8) ? 4'd0 :
                      head_word[`OPC_MSB:`OPC_LSB];
   assign head_dst  = head_word[`DST_MSB:`DST_LSB];
   assign head_src  = head_word[`SRC_MSB:`SRC_LSB];
   assign head_imm  = head_word[`IMM_MSB:0];
   assign exp_data  = model_result(head_op, model_regs[head_dst], model_regs[head_src], head_imm);

   always @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr  <= 0;
         rd_ptr  <= 0;
         mem_cnt <= 0;
         for (int i = 0; i < `REG_COUNT; i++)
            model_regs[i] <= '0;
      end else begin
         if (instr_valid && instr_ready) begin
            fifo_mem[wr_ptr] <= instr_word;
            wr_ptr           <= wr_ptr + 1;
         end
         if (commit_valid) begin
            if (head_op != op_nop && head_op != op_store)
               model_regs[head_dst] <= exp_data;
            rd_ptr <= rd_ptr + 1;
         end
         if (wmem_valid && wmem_ready)
            mem_cnt <= mem_cnt + 1;
      end
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt > TIMEOUT_CYCLES)
         report_failure("Timeout: not every instruction retired within the cycle limit");
   end

   // Store port back-pressure
   always @(posedge clk) begin
      #2;
      if (rst_n)
         wmem_ready = ($random(seed) & 3) != 0;
   end

   a_reset_idle : assert property (@(posedge clk)
      !rst_n |=> !commit_valid && !wmem_valid && instr_ready)
      else report_failure("Outputs not idle during or right after reset");

   a_commit_queued : assert property (@(posedge clk) disable iff (!rst_n)
      commit_valid |-> rd_ptr < wr_ptr)
      else report_failure("Commit seen with no instruction outstanding");

   a_commit_opcode : assert property (@(posedge clk) disable iff (!rst_n)
      commit_valid |-> commit_opcode == head_op)
      else report_failure($sformatf("** Error: commit_opcode expected %h, got %h",
                                    $sampled(head_op), $sampled(commit_opcode)));

   a_commit_reg : assert property (@(posedge clk) disable iff (!rst_n)
      commit_valid |-> commit_reg == head_dst)
      else report_failure($sformatf("** Error: commit_reg expected %h, got %h",
                                    $sampled(head_dst), $sampled(commit_reg)));

   a_commit_data : assert property (@(posedge clk) disable iff (!rst_n)
      commit_valid |-> commit_data == exp_data)
      else report_failure($sformatf("** Error: commit_data expected %h, got %h",
                                    $sampled(exp_data), $sampled(commit_data)));

   a_store_is_head : assert property (@(posedge clk) disable iff (!rst_n)
      wmem_valid && wmem_ready |-> head_op == op_store)
      else report_failure("Store handshake while the oldest instruction is not a store");

   a_store_addr : assert property (@(posedge clk) disable iff (!rst_n)
      wmem_valid && wmem_ready |-> wmem_address == head_imm)
      else report_failure($sformatf("** Error: wmem_address expected %h, got %h",
                                    $sampled(head_imm), $sampled(wmem_address)));

   a_store_data : assert property (@(posedge clk) disable iff (!rst_n)
      wmem_valid && wmem_ready |-> wmem_data == exp_data)
      else report_failure($sformatf("** Error: wmem_data expected %h, got %h",
                                    $sampled(exp_data), $sampled(wmem_data)));

   a_store_stall : assert property (@(posedge clk) disable iff (!rst_n)
      wmem_valid && !wmem_ready |=>
      wmem_valid && $stable(wmem_address) && $stable(wmem_data))
      else report_failure("Store request dropped or changed while wmem_ready was low");

   initial begin
      seed        = 32'hbc6d40f9;
      stores_sent = 0;
      rst_n       = 1'b0;
      instr_valid = 1'b0;
      instr_word  = '0;
      wmem_ready  = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst_n = 1'b1;

      // Known value in every register first
      for (int i = 0; i < `REG_COUNT; i++)
         send_instr({4'(op_movi), 3'(i), 3'd0, 6'd0, 16'($random(seed))});
      for (int i = 0; i < NUM_RANDOM; i++)
         send_instr(random_instr());

      while (wr_ptr < NUM_INSTR || rd_ptr < wr_ptr)
         @(posedge clk);
      repeat (20) @(posedge clk);

      a_commit_count : assert (rd_ptr == wr_ptr && wr_ptr == NUM_INSTR)
         else report_failure("Number of commits differs from accepted instructions");
      a_store_count : assert (mem_cnt == stores_sent)
         else report_failure("Number of store handshakes differs from stores sent");
      $display("TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire
